//--- Makefile
# Verilator simulation of the five-stage core
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search for the pass message"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module procTb -f flist.f --Mdir build -o procSim
	@out="$$(./build/procSim)"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf build

//--- flist.f
logic/procPkg.sv
logic/runControl.sv
logic/hazardTimer.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeMemory.sv
logic/proc.sv
test/procTb.sv

//--- logic/decodeStage.sv
/*
 * Decode: field extraction through the instruction union, register file with
 * write-through and debug read, branch resolution, and the decode/execute latch.
 */
`timescale 1ns/1ps

module decodeStage import procPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic                    stall,
    input  instrWord                fetchInstr,
    input  logic [memAddrWidth-1:0] fetchPc,
    input  logic                    wbWe,
    input  logic [regAddrWidth-1:0] wbAddr,
    input  logic [dataWidth-1:0]    wbData,
    input  logic [regAddrWidth-1:0] dbgAddr,
    output logic [dataWidth-1:0]    dbgData,
    output logic                    redirect,
    output logic [memAddrWidth-1:0] target,
    output logic [regAddrWidth-1:0] srcA,
    output logic [regAddrWidth-1:0] srcB,
    output logic [1:0]              srcValid,
    output logic                    issue,
    output logic                    issueWrites,
    output logic [regAddrWidth-1:0] issueDest,
    output logic                    illegal,
    output logic [4:0]              exOp,
    output logic [1:0]              exFunct,
    output logic [dataWidth-1:0]    exA,
    output logic [dataWidth-1:0]    exB,
    output logic [dataWidth-1:0]    exImm,
    output logic [regAddrWidth-1:0] exDest,
    output logic                    exWrites,
    output logic                    exHalt
);

    logic [dataWidth-1:0] regs [2**regAddrWidth];
    logic                 haltSeen;   // HALT issued, decode holds
    logic                 active;
    logic                 legal;
    logic [1:0]           srcUse;
    logic [4:0]           op;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] valA;
    logic [dataWidth-1:0] valB;

    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] idx);
        readReg = (wbWe && wbAddr == idx) ? wbData : regs[idx];   // Write-through
    endfunction

    assign op     = fetchInstr.rFmt.opcode;
    assign srcA   = fetchInstr.rFmt.rs;        // Same bits in every format
    assign active = run && !haltSeen;

    always_comb begin
        legal       = 1'b1;
        issueWrites = 1'b0;
        srcUse      = 2'b00;
        srcB        = fetchInstr.rFmt.rt;
        issueDest   = fetchInstr.iFmt.rd;
        immExt      = {{(dataWidth-5){fetchInstr.iFmt.imm5[4]}}, fetchInstr.iFmt.imm5};
        case (op)
            opAddi, opLd: begin
                issueWrites = 1'b1;
                srcUse      = 2'b01;
            end
            opSt: begin
                srcUse = 2'b11;                                    // Store data sits in rt bits
            end
            opBeqz: begin
                srcUse = 2'b01;
                immExt = {{(dataWidth-8){fetchInstr.bFmt.imm8[7]}}, fetchInstr.bFmt.imm8};
            end
            opJ: immExt = {{(dataWidth-11){fetchInstr.jFmt.disp11[10]}}, fetchInstr.jFmt.disp11};
            opRfmt: begin
                issueWrites = 1'b1;
                srcUse      = 2'b11;
                issueDest   = fetchInstr.rFmt.rd;
            end
            opHalt, opNop: legal = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    assign srcValid = active ? srcUse : 2'b00;
    assign issue    = active && !stall && legal;
    assign illegal  = active && !legal;          // Never issued
    assign valA     = readReg(srcA);
    assign valB     = readReg(srcB);
    assign dbgData  = regs[dbgAddr];

    // Branches resolve here, relative to PC+1
    assign redirect = issue && ((op == opBeqz && valA == '0) || op == opJ);
    assign target   = fetchPc + immExt[memAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrWidth; i++)
                regs[i] <= '0;
        end else if (wbWe) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) haltSeen <= 1'b0;
        else if (issue && op == opHalt) haltSeen <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exOp     <= opNop;
            exWrites <= 1'b0;
            exHalt   <= 1'b0;
        end else begin
            exOp     <= issue ? op : opNop;            // Bubble when not issuing
            exWrites <= issue && issueWrites;
            exHalt   <= issue && op == opHalt;
        end
    end

    always_ff @(posedge clk) begin
        exFunct <= fetchInstr.rFmt.funct;
        exA     <= valA;
        exB     <= valB;
        exImm   <= immExt;
        exDest  <= issueDest;
    end

endmodule

//--- logic/executeMemory.sv
/*
 * Back end of the pipe: ALU, execute/memory latch, 256-word data store,
 * memory/writeback latch and the writeback select toward the register file.
 */
`timescale 1ns/1ps

module executeMemory import procPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic [4:0]              exOp,
    input  logic [1:0]              exFunct,
    input  logic [dataWidth-1:0]    exA,
    input  logic [dataWidth-1:0]    exB,
    input  logic [dataWidth-1:0]    exImm,
    input  logic [regAddrWidth-1:0] exDest,
    input  logic                    exWrites,
    input  logic                    exHalt,
    output logic                    wbWe,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [dataWidth-1:0]    wbData,
    output logic                    haltDone
);

    logic [dataWidth-1:0]    dataMem [2**memAddrWidth];
    logic [dataWidth-1:0]    aluOut;
    logic [dataWidth-1:0]    memAlu;       // Result or address
    logic [dataWidth-1:0]    memStData;
    logic [dataWidth-1:0]    memRdData;
    logic [regAddrWidth-1:0] memDest;
    logic                    memStore;
    logic                    memLoad;
    logic                    memWrites;
    logic                    memHalt;
    logic [dataWidth-1:0]    wbAlu;
    logic [dataWidth-1:0]    wbMem;
    logic                    wbLoad;
    logic                    wbHalt;

    always_comb begin
        case (exOp)
            opRfmt: begin
                case (exFunct)
                    fnAdd:  aluOut = exA + exB;
                    fnSub:  aluOut = exA - exB;
                    fnXor:  aluOut = exA ^ exB;
                    fnAndn: aluOut = exA & ~exB;
                endcase
            end
            opAddi, opLd, opSt: aluOut = exA + exImm;   // Also the memory address
            default: aluOut = exA;
        endcase
    end

    // Back end keeps draining once stopped, so older instructions still retire
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memStore  <= 1'b0;
            memLoad   <= 1'b0;
            memWrites <= 1'b0;
            memHalt   <= 1'b0;
            wbWe      <= 1'b0;
            wbHalt    <= 1'b0;
        end else begin
            memStore  <= (exOp == opSt);
            memLoad   <= (exOp == opLd);
            memWrites <= exWrites;
            memHalt   <= exHalt;
            wbWe      <= memWrites;                  // Register 0 is writable
            wbHalt    <= memHalt;
        end
    end

    always_ff @(posedge clk) begin
        memAlu    <= aluOut;
        memStData <= exB;
        memDest   <= exDest;
        wbAlu     <= memAlu;
        wbMem     <= memRdData;
        wbLoad    <= memLoad;
        wbAddr    <= memDest;
    end

    always_ff @(posedge clk) begin
        if (memStore) dataMem[memAlu[memAddrWidth-1:0]] <= memStData;
    end

    assign memRdData = dataMem[memAlu[memAddrWidth-1:0]];   // Asynchronous read
    assign wbData    = wbLoad ? wbMem : wbAlu;
    assign haltDone  = wbHalt && run;                      // All older writes done

endmodule

//--- logic/fetchStage.sv
/*
 * Fetch: PC, 256-word instruction store and the fetch/decode latch.
 * The store is loaded through the imem port while the core is stopped.
 */
`timescale 1ns/1ps

module fetchStage import procPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic                    stall,
    input  logic                    redirect,     // Taken branch or jump in decode
    input  logic [memAddrWidth-1:0] target,
    input  logic                    imemWe,
    input  logic [memAddrWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0]    imemData,
    output instrWord                fetchInstr,
    output logic [memAddrWidth-1:0] fetchPc       // PC+1 of fetchInstr
);

    logic [dataWidth-1:0]    instrMem [2**memAddrWidth];
    logic [memAddrWidth-1:0] pc;
    logic                    advance;

    assign advance = run && !stall;   // Stall holds PC and latch

    always_ff @(posedge clk) begin
        if (imemWe && !run) instrMem[imemAddr] <= imemData;   // Program load
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= '0;
            fetchInstr <= nopWord;
        end else if (advance) begin
            if (redirect) begin
                pc         <= target;
                fetchInstr <= nopWord;                    // Flush the slot behind
            end else begin
                pc         <= pc + 1'b1;                  // Word addressed
                fetchInstr <= instrMem[pc];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !redirect) fetchPc <= pc + 1'b1;
    end

    // Program loads only happen with the pipeline stopped
    assert property (@(posedge clk) disable iff (!rstN) !(imemWe && run));

endmodule

//--- logic/hazardTimer.sv
/*
 * Pending-write tracking per register. Decode reports the sources it needs;
 * stall stays high while any of them still has a write in flight.
 */
`timescale 1ns/1ps

module hazardTimer import procPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic [regAddrWidth-1:0] srcA,
    input  logic [regAddrWidth-1:0] srcB,
    input  logic [1:0]              srcValid,   // Bit 0 for srcA, bit 1 for srcB
    input  logic                    issue,
    input  logic                    issueWrites,
    input  logic [regAddrWidth-1:0] issueDest,
    output logic                    stall
);

    logic [timerWidth-1:0] timer [2**regAddrWidth];   // Cycles left per register
    logic [timerWidth:0]   stallRun;                  // Consecutive stalled cycles

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrWidth; i++)
                timer[i] <= '0;
        end else if (run) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                if (issue && issueWrites && issueDest == regAddrWidth'(i))
                    timer[i] <= pendingCycles;           // New write in flight
                else if (timer[i] != '0)
                    timer[i] <= timer[i] - 1'b1;
            end
        end
    end

    assign stall = (srcValid[0] && timer[srcA] != '0) ||
                   (srcValid[1] && timer[srcB] != '0);

    always_ff @(posedge clk) begin
        if (!rstN) stallRun <= '0;
        else if (run) stallRun <= stall ? stallRun + 1'b1 : '0;
    end

    // A stalled instruction waits out one timer at most
    assert property (@(posedge clk) disable iff (!rstN) stallRun <= {1'b0, pendingCycles});

endmodule

//--- logic/proc.sv
/*
 * Top of the five-stage core. Load the program through imem while idle,
 * pulse start, wait for halted or err, then read registers on the debug port.
 */
`timescale 1ns/1ps

module proc import procPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    imemWe,
    input  logic [memAddrWidth-1:0] imemAddr,
    input  logic [dataWidth-1:0]    imemData,
    input  logic                    start,
    input  logic [regAddrWidth-1:0] dbgAddr,
    output logic                    running,
    output logic                    halted,
    output logic                    err,
    output logic [dataWidth-1:0]    dbgData
);

    logic                    run, illegal, haltDone, stall;
    logic                    redirect, issue, issueWrites;
    logic [memAddrWidth-1:0] target, fetchPc;
    instrWord                fetchInstr;
    logic [regAddrWidth-1:0] srcA, srcB, issueDest, exDest, wbAddr;
    logic [1:0]              srcValid, exFunct;
    logic [4:0]              exOp;
    logic [dataWidth-1:0]    exA, exB, exImm, wbData;
    logic                    exWrites, exHalt, wbWe;

    runControl ctrl (
        .clk(clk), .rstN(rstN), .start(start), .illegal(illegal), .haltDone(haltDone),
        .run(run), .running(running), .halted(halted), .err(err)
    );

    hazardTimer hazard (
        .clk(clk), .rstN(rstN), .run(run), .srcA(srcA), .srcB(srcB), .srcValid(srcValid),
        .issue(issue), .issueWrites(issueWrites), .issueDest(issueDest), .stall(stall)
    );

    fetchStage fetch (
        .clk(clk), .rstN(rstN), .run(run), .stall(stall),
        .redirect(redirect), .target(target),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .fetchInstr(fetchInstr), .fetchPc(fetchPc)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN), .run(run), .stall(stall),
        .fetchInstr(fetchInstr), .fetchPc(fetchPc),
        .wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData),
        .dbgAddr(dbgAddr), .dbgData(dbgData), .redirect(redirect), .target(target),
        .srcA(srcA), .srcB(srcB), .srcValid(srcValid), .issue(issue),
        .issueWrites(issueWrites), .issueDest(issueDest), .illegal(illegal),
        .exOp(exOp), .exFunct(exFunct), .exA(exA), .exB(exB), .exImm(exImm),
        .exDest(exDest), .exWrites(exWrites), .exHalt(exHalt)
    );

    executeMemory backEnd (
        .clk(clk), .rstN(rstN), .run(run),
        .exOp(exOp), .exFunct(exFunct), .exA(exA), .exB(exB), .exImm(exImm),
        .exDest(exDest), .exWrites(exWrites), .exHalt(exHalt),
        .wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData), .haltDone(haltDone)
    );

endmodule

//--- logic/procPkg.sv
/*
 * Shared definitions for the 16-bit pipelined core.
 * Every RTL block takes sizes, opcodes, the instruction word and run states from here.
 */
package procPkg;

    localparam int dataWidth    = 16;   // Machine word
    localparam int regAddrWidth = 3;    // Eight registers
    localparam int memAddrWidth = 8;    // 256 words per memory

    // WISC-style opcodes, top five bits of the word
    localparam logic [4:0] opHalt = 5'b00000;
    localparam logic [4:0] opNop  = 5'b00001;
    localparam logic [4:0] opJ    = 5'b00100;
    localparam logic [4:0] opAddi = 5'b01000;
    localparam logic [4:0] opBeqz = 5'b01100;
    localparam logic [4:0] opSt   = 5'b10000;
    localparam logic [4:0] opLd   = 5'b10001;
    localparam logic [4:0] opRfmt = 5'b11011;   // ADD/SUB/XOR/ANDN group

    localparam logic [1:0] fnAdd  = 2'b00;
    localparam logic [1:0] fnSub  = 2'b01;   // rs - rt
    localparam logic [1:0] fnXor  = 2'b10;
    localparam logic [1:0] fnAndn = 2'b11;   // rs & ~rt

    localparam logic [dataWidth-1:0] nopWord = {opNop, 11'd0};   // Flush and reset filler

    localparam int timerWidth = 2;
    localparam logic [timerWidth-1:0] pendingCycles = 2'd3;   // Issue to visible write

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] funct;
    } rFmtFields;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;      // Destination, or store data source for ST
        logic [4:0] imm5;
    } iFmtFields;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [7:0] imm8;
    } bFmtFields;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [10:0] disp11;
    } jFmtFields;

    typedef union packed {
        rFmtFields rFmt;
        iFmtFields iFmt;
        bFmtFields bFmt;
        jFmtFields jFmt;
    } instrWord;   // One fetched word, four views

    typedef enum logic [1:0] {stIdle, stRunning, stHalted, stFault} runState;

endpackage

//--- logic/runControl.sv
/*
 * Run sequencer of the core: idle until start, then running until a HALT
 * retires or decode flags an illegal opcode. Halted and fault hold until reset.
 */
`timescale 1ns/1ps

module runControl import procPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic start,      // One-cycle pulse from outside
    input  logic illegal,    // Unknown opcode in decode
    input  logic haltDone,   // HALT left the MEM/WB latch
    output logic run,
    output logic running,
    output logic halted,
    output logic err
);

    runState state;
    runState nextState;

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (start) nextState = stRunning;
            end
            stRunning: begin
                if (illegal) nextState = stFault;            // Fault wins a tie
                else if (haltDone) nextState = stHalted;
            end
            default: nextState = state;                      // Halted and fault are final
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) state <= stIdle;
        else state <= nextState;
    end

    assign running = (state == stRunning);
    assign run     = running;                 // Pipeline enable
    assign halted  = (state == stHalted);
    assign err     = (state == stFault);

    // Only one way out of a run
    assert property (@(posedge clk) disable iff (!rstN) !(halted && err));

endmodule

//--- test/procTb.sv
/*
 * Directed testbench for the pipelined core. Each test loads a program, predicts
 * its outcome with an instruction-level model, runs the DUT until halted or err,
 * then compares the run state and every register read back over the debug port.
 */
`timescale 1ns/1ps

module procTb import procPkg::*; ();

    logic                    clk;
    logic                    rstN;
    logic                    imemWe;
    logic [memAddrWidth-1:0] imemAddr;
    logic [dataWidth-1:0]    imemData;
    logic                    start;
    logic [regAddrWidth-1:0] dbgAddr;
    logic                    running;
    logic                    halted;
    logic                    err;
    logic [dataWidth-1:0]    dbgData;

    logic [dataWidth-1:0] prog [$];                        // Program under test
    logic [dataWidth-1:0] modelRegs [2**regAddrWidth];     // Predicted final registers
    logic [dataWidth-1:0] modelMem [2**memAddrWidth];
    logic [31:0]          lcgState = 32'he5c2;
    int                   errCount = 0;
    int                   checkCount = 0;
    int                   testCount = 0;
    int                   failCount = 0;

    proc i_dut (
        .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .start(start), .dbgAddr(dbgAddr), .running(running), .halted(halted), .err(err),
        .dbgData(dbgData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];   // Upper bits mix best
    endfunction

    function automatic logic [dataWidth-1:0] encR(input logic [1:0] funct,
            input logic [2:0] rd, input logic [2:0] rs, input logic [2:0] rt);
        instrWord w;
        w.rFmt = {opRfmt, rs, rt, rd, funct};
        return w;
    endfunction

    function automatic logic [dataWidth-1:0] encI(input logic [4:0] op,
            input logic [2:0] rs, input logic [2:0] rd, input logic [4:0] imm5);
        instrWord w;
        w.iFmt = {op, rs, rd, imm5};   // rd is the data source for ST
        return w;
    endfunction

    function automatic logic [dataWidth-1:0] encB(input logic [2:0] rs, input logic [7:0] imm8);
        instrWord w;
        w.bFmt = {opBeqz, rs, imm8};
        return w;
    endfunction

    function automatic logic [dataWidth-1:0] encJ(input logic [10:0] disp11);
        instrWord w;
        w.jFmt = {opJ, disp11};
        return w;
    endfunction

    // Sequential ISA semantics, branch targets relative to the next PC
    task automatic runModel(output runState outcome);
        instrWord                w;
        logic [memAddrWidth-1:0] pc;
        logic [dataWidth-1:0]    a;
        logic [dataWidth-1:0]    b;
        logic [dataWidth-1:0]    imm;
        logic [memAddrWidth-1:0] addr;
        int                      steps;
        for (int i = 0; i < 2**regAddrWidth; i++)
            modelRegs[i] = '0;                              // Register reset value
        for (int i = 0; i < 2**memAddrWidth; i++)
            modelMem[i] = '0;
        pc      = '0;
        steps   = 0;
        outcome = stRunning;
        while (outcome == stRunning && steps < 1000) begin
            w    = (int'(pc) < prog.size()) ? prog[pc] : {opHalt, 11'd0};
            a    = modelRegs[w.iFmt.rs];
            b    = modelRegs[w.rFmt.rt];
            imm  = {{(dataWidth-5){w.iFmt.imm5[4]}}, w.iFmt.imm5};
            addr = memAddrWidth'(a + imm);
            pc   = pc + 8'd1;
            case (w.rFmt.opcode)
                opHalt: outcome = stHalted;
                opNop:  ;
                opAddi: modelRegs[w.iFmt.rd] = a + imm;
                opLd:   modelRegs[w.iFmt.rd] = modelMem[addr];
                opSt:   modelMem[addr] = modelRegs[w.iFmt.rd];
                opBeqz: if (a == '0) pc = pc + w.bFmt.imm8;
                opJ:    pc = pc + w.jFmt.disp11[memAddrWidth-1:0];   // Wraps in 256 words
                opRfmt: begin
                    case (w.rFmt.funct)
                        fnAdd:   modelRegs[w.rFmt.rd] = a + b;
                        fnSub:   modelRegs[w.rFmt.rd] = a - b;
                        fnXor:   modelRegs[w.rFmt.rd] = a ^ b;
                        default: modelRegs[w.rFmt.rd] = a & ~b;   // ANDN
                    endcase
                end
                default: outcome = stFault;                      // Unknown opcode stops it
            endcase
            steps++;
        end
    endtask

    task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] expected);
        checkCount++;
        if (got !== expected) begin
            errCount++;
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, got);
        end
    endtask

    task automatic checkState(input runState expected);
        runState actual;
        checkCount++;
        actual = running ? stRunning : halted ? stHalted : err ? stFault : stIdle;
        if (int'(running) + int'(halted) + int'(err) > 1) begin
            errCount++;
            $display("more than one of running, halted and err is high at once");
        end else if (actual !== expected) begin
            errCount++;
            $display("[ERROR] runState: expected 0x%h, got 0x%h", expected, actual);
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        rstN   = 1'b0;
        start  = 1'b0;
        imemWe = 1'b0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            imemWe   = 1'b1;                   // Core is idle here
            imemAddr = memAddrWidth'(i);
            imemData = prog[i];
        end
        @(negedge clk);
        imemWe = 1'b0;
    endtask

    task automatic pulseStart();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic waitDone(input int limit);
        int n;
        n = 0;
        while (!halted && !err && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!halted && !err) begin
            errCount++;
            $display("timeout: core neither halted nor faulted within %0d cycles", limit);
        end
        repeat (4) @(negedge clk);             // Older writes drain after a fault
    endtask

    task automatic checkRegs();
        for (int i = 0; i < 2**regAddrWidth; i++) begin
            dbgAddr = regAddrWidth'(i);
            @(negedge clk);
            checkWord($sformatf("r%0d", i), dbgData, modelRegs[i]);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errCount == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errCount - errorsBefore);
        end
    endtask

    task automatic runProgram(input string name);
        runState expected;
        int      errorsBefore;
        errorsBefore = errCount;
        applyReset();
        loadProgram();
        runModel(expected);
        pulseStart();
        waitDone(500);
        checkState(expected);
        checkRegs();
        reportTest(name, errorsBefore);
    endtask

    task automatic testReset();
        runState expected;
        int      errorsBefore;
        errorsBefore = errCount;
        prog.delete();
        prog.push_back({opHalt, 11'd0});
        applyReset();
        checkState(stIdle);
        loadProgram();
        runModel(expected);
        pulseStart();
        checkState(stRunning);                 // One edge after start
        waitDone(500);
        checkState(expected);
        checkRegs();
        reportTest("reset", errorsBefore);
    endtask

    task automatic testArith();
        logic [15:0]             r;
        logic [regAddrWidth-1:0] prev;
        prog.delete();
        for (int i = 0; i < 2**regAddrWidth; i++) begin
            r = nextRand();
            prog.push_back(encI(opAddi, r[2:0], regAddrWidth'(i), r[8:4]));
        end
        prev = 3'd7;
        for (int k = 0; k < 10; k++) begin
            r = nextRand();
            prog.push_back(encR(r[1:0], r[4:2], prev, r[7:5]));   // Reads the last result
            prev = r[4:2];
        end
        prog.push_back({opHalt, 11'd0});
        runProgram("arith");
    endtask

    task automatic testMemory();
        logic [15:0] r;
        logic [4:0]  off [3];
        prog.delete();
        r = nextRand();
        prog.push_back(encI(opAddi, 3'd0, 3'd1, {1'b0, r[3:0]}));   // Base in r1
        for (int k = 0; k < 3; k++) begin
            r      = nextRand();
            off[k] = 5'(k * 4) + {3'b000, r[1:0]} - 5'd6;          // Distinct, some negative
            prog.push_back(encI(opAddi, 3'd0, 3'(k + 2), r[9:5]));
        end
        for (int k = 0; k < 3; k++)
            prog.push_back(encI(opSt, 3'd1, 3'(k + 2), off[k]));
        for (int k = 0; k < 3; k++)
            prog.push_back(encI(opLd, 3'd1, 3'(k + 5), off[2 - k]));   // Reverse order
        prog.push_back(encI(opSt, 3'd1, 3'd5, 5'd9));
        prog.push_back(encI(opLd, 3'd1, 3'd0, 5'd9));             // Load right behind store
        prog.push_back({opHalt, 11'd0});
        runProgram("memory");
    endtask

    task automatic testControl();
        logic [15:0] r;
        r = nextRand();
        prog.delete();
        prog.push_back(encI(opAddi, 3'd0, 3'd1, 5'd0));                  // 0: r1 = 0
        prog.push_back(encI(opAddi, 3'd0, 3'd2, {1'b0, r[3:0]} | 5'd1)); // 1: r2 nonzero
        prog.push_back(encB(3'd1, 8'd1));                                // 2: taken, to 4
        prog.push_back(encI(opAddi, 3'd0, 3'd3, r[8:4] | 5'd1));         // 3: flushed marker
        prog.push_back(encB(3'd2, 8'd2));                                // 4: not taken
        prog.push_back(encI(opAddi, 3'd0, 3'd4, r[13:9] | 5'd1));        // 5: executes
        prog.push_back(encJ(11'd2));                                     // 6: forward, to 9
        prog.push_back(encI(opAddi, 3'd0, 3'd5, 5'd11));                 // 7: flushed marker
        prog.push_back({opHalt, 11'd0});                                 // 8
        prog.push_back(encI(opAddi, 3'd4, 3'd6, r[4:0]));                // 9: executes
        prog.push_back(encJ(11'h7fd));                                   // 10: back to 8
        prog.push_back(encI(opAddi, 3'd0, 3'd7, 5'd13));                 // 11: flushed marker
        runProgram("control");
    endtask

    task automatic testIllegal();
        logic [15:0] r;
        r = nextRand();
        prog.delete();
        prog.push_back(encI(opAddi, 3'd0, 3'd1, r[4:0]));
        prog.push_back(encI(opAddi, 3'd1, 3'd2, r[9:5]));
        prog.push_back(encI(opAddi, 3'd2, 3'd3, r[14:10]));
        prog.push_back({5'b11111, r[10:0]});                 // Undefined opcode
        prog.push_back(encI(opAddi, 3'd0, 3'd4, 5'd3));      // Must never retire
        prog.push_back(encI(opAddi, 3'd0, 3'd5, 5'd7));
        prog.push_back({opHalt, 11'd0});
        runProgram("illegal");
    endtask

    initial begin
        rstN     = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        start    = 1'b0;
        dbgAddr  = '0;
        testReset();
        testArith();
        testMemory();
        testControl();
        testIllegal();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failCount, checkCount, errCount);
        if (errCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
